// File: flist.f
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/operand_unit.sv
hw/branch_unit.sv
hw/id_stage.sv
verif/tb_id_stage.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f flist.f --top-module tb_id_stage -o sim_id_stage
out=$(./obj_dir/sim_id_stage || true)
echo "$out"

if echo "$out" | grep -q "Done: no errors"; then
    exit 0
else
    exit 1
fi

// File: verif/tb_id_stage.sv
module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;

    // one-hot alu codes, bit order add sub slt sltu and nor or xor sll srl sra lui
    localparam isa_pkg::alu_op_t ALU_ADD = 12'h001;
    localparam isa_pkg::alu_op_t ALU_SUB = 12'h002;
    localparam isa_pkg::alu_op_t ALU_OR  = 12'h040;
    localparam isa_pkg::alu_op_t ALU_SLL = 12'h100;
    localparam isa_pkg::alu_op_t ALU_LUI = 12'h800;

    logic                  clk;
    logic                  reset;
    logic                  flush;
    logic                  fs_to_ds_valid;
    pipe_pkg::fetch_pkt_t  fs_to_ds_bus;
    logic                  ds_allowin;
    logic                  es_allowin;
    logic                  ds_to_es_valid;
    pipe_pkg::ds_to_es_t   ds_to_es_bus;
    pipe_pkg::wb_pkt_t     ws_to_rf;
    pipe_pkg::hazard_bus_t hazard_bus;
    pipe_pkg::br_pkt_t     br_bus;

    int errors;
    int checks;
    int tests;

    id_stage u_id_stage (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .ds_allowin     (ds_allowin),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .ws_to_rf       (ws_to_rf),
        .hazard_bus     (hazard_bus),
        .br_bus         (br_bus)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic isa_pkg::word_t r_type(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                             logic [4:0] sa, logic [5:0] fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic isa_pkg::word_t i_type(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                             logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic isa_pkg::word_t br_target(isa_pkg::word_t pc, logic [15:0] off);
        return pc + 32'd4 + {{14{off[15]}}, off, 2'b00};
    endfunction

    task automatic compare_word(string name, isa_pkg::word_t got, isa_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_reg(string name, isa_pkg::reg_idx_t got, isa_pkg::reg_idx_t exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_alu(string name, isa_pkg::alu_op_t got, isa_pkg::alu_op_t exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(string what);
        $display("TIMEOUT t=%0t %s", $time, what);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic write_reg(isa_pkg::reg_idx_t idx, isa_pkg::word_t data);
        @(negedge clk);
        ws_to_rf = '{1'b1, idx, data};
        @(negedge clk);
        ws_to_rf.we = 1'b0;
    endtask

    // hand one instruction to the stage, return with it held and settled
    task automatic issue(isa_pkg::word_t pc, isa_pkg::word_t inst);
        int n;
        n = 0;
        @(negedge clk);
        while (!ds_allowin) begin
            if (n >= 20)
                abort_run("ds_allowin stayed low");
            n++;
            @(negedge clk);
        end
        fs_to_ds_valid = 1'b1;
        fs_to_ds_bus   = '{pc, inst};
        @(negedge clk);
        fs_to_ds_valid = 1'b0;
        #2;
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (!ds_to_es_valid) begin
            if (n >= 20)
                abort_run("ds_to_es_valid never rose");
            n++;
            @(negedge clk);
            #2;
        end
    endtask

    task automatic end_test(string name, int start);
        tests++;
        $display("test %s finished with %0d errors", name, errors - start);
    endtask

    task automatic alu_ops();
        int start;
        isa_pkg::word_t d1;
        isa_pkg::word_t d2;
        start = errors;
        d1 = $urandom();
        d2 = $urandom();
        compare_bit("ds_to_es_valid", ds_to_es_valid, 1'b0);
        compare_bit("br_bus.taken", br_bus.taken, 1'b0);
        compare_bit("ds_allowin", ds_allowin, 1'b1);
        write_reg(5'd1, d1);
        write_reg(5'd2, d2);
        issue(32'h100, r_type(5'd1, 5'd2, 5'd3, 5'd0, 6'h21));  // addu
        wait_valid();
        compare_alu("alu_op addu", ds_to_es_bus.alu_op, ALU_ADD);
        compare_reg("dest", ds_to_es_bus.dest, 5'd3);
        compare_bit("gr_we", ds_to_es_bus.gr_we, 1'b1);
        compare_word("rs_value", ds_to_es_bus.rs_value, d1);
        compare_word("rt_value", ds_to_es_bus.rt_value, d2);
        compare_word("pc", ds_to_es_bus.pc, 32'h100);
        issue(32'h104, r_type(5'd2, 5'd1, 5'd4, 5'd0, 6'h23));  // subu
        wait_valid();
        compare_alu("alu_op subu", ds_to_es_bus.alu_op, ALU_SUB);
        compare_word("rs_value", ds_to_es_bus.rs_value, d2);
        issue(32'h108, r_type(5'd1, 5'd2, 5'd5, 5'd0, 6'h25));  // or
        wait_valid();
        compare_alu("alu_op or", ds_to_es_bus.alu_op, ALU_OR);
        compare_reg("dest", ds_to_es_bus.dest, 5'd5);
        issue(32'h10c, r_type(5'd0, 5'd2, 5'd6, 5'd7, 6'h00));  // sll
        wait_valid();
        compare_alu("alu_op sll", ds_to_es_bus.alu_op, ALU_SLL);
        compare_bit("src1_is_sa", ds_to_es_bus.src1_is_sa, 1'b1);
        compare_word("rt_value", ds_to_es_bus.rt_value, d2);
        write_reg(5'd0, d1);  // r0 ignores writes
        issue(32'h110, r_type(5'd0, 5'd1, 5'd7, 5'd0, 6'h21));  // r0 source
        wait_valid();
        compare_word("rs_value r0", ds_to_es_bus.rs_value, 32'h0);
        end_test("alu_basic", start);
    endtask

    task automatic imm_forms();
        int start;
        isa_pkg::imm_t imm;
        start = errors;
        imm = isa_pkg::imm_t'($urandom());
        issue(32'h200, i_type(6'h0d, 5'd1, 5'd6, imm));  // ori
        wait_valid();
        compare_reg("dest ori", ds_to_es_bus.dest, 5'd6);
        compare_bit("src2_is_uimm", ds_to_es_bus.src2_is_uimm, 1'b1);
        compare_word("imm", 32'(ds_to_es_bus.imm), 32'(imm));
        issue(32'h204, i_type(6'h0f, 5'd0, 5'd7, imm));  // lui
        wait_valid();
        compare_alu("alu_op lui", ds_to_es_bus.alu_op, ALU_LUI);
        compare_reg("dest lui", ds_to_es_bus.dest, 5'd7);
        compare_bit("src2_is_imm", ds_to_es_bus.src2_is_imm, 1'b1);
        issue(32'h208, i_type(6'h23, 5'd1, 5'd8, imm));  // lw
        wait_valid();
        compare_reg("dest lw", ds_to_es_bus.dest, 5'd8);
        compare_word("ld_ext lw", 32'(ds_to_es_bus.ld_ext), 32'b00001);
        compare_bit("src2_is_imm", ds_to_es_bus.src2_is_imm, 1'b1);
        compare_bit("load_op lw", ds_to_es_bus.load_op, 1'b1);
        issue(32'h20c, i_type(6'h24, 5'd1, 5'd9, imm));  // lbu
        wait_valid();
        compare_word("ld_ext lbu", 32'(ds_to_es_bus.ld_ext), 32'b01000);
        issue(32'h210, i_type(6'h29, 5'd1, 5'd2, imm));  // sh
        wait_valid();
        compare_word("st_size sh", 32'(ds_to_es_bus.st_size), 32'b010);
        compare_bit("gr_we sh", ds_to_es_bus.gr_we, 1'b0);
        compare_bit("store_op sh", ds_to_es_bus.store_op, 1'b1);
        end_test("imm_forms", start);
    endtask

    task automatic branch_redirects();
        int start;
        isa_pkg::word_t pc;
        isa_pkg::word_t pc4;
        isa_pkg::word_t d1;
        isa_pkg::imm_t off;
        logic [25:0] idx;
        start = errors;
        pc  = 32'h0000_1000;
        pc4 = pc + 32'd4;
        d1  = $urandom();
        off = isa_pkg::imm_t'($urandom());
        idx = 26'($urandom());
        write_reg(5'd1, d1);
        write_reg(5'd2, ~d1);
        write_reg(5'd9, 32'h8000_0000 | $urandom());  // negative
        write_reg(5'd10, $urandom() >> 1);  // non-negative
        issue(pc, i_type(6'h04, 5'd1, 5'd1, off));  // beq equal
        compare_bit("taken beq eq", br_bus.taken, 1'b1);
        compare_word("target beq", br_bus.target, br_target(pc, off));
        issue(pc, i_type(6'h04, 5'd1, 5'd2, off));
        compare_bit("taken beq ne", br_bus.taken, 1'b0);
        issue(pc, i_type(6'h01, 5'd9, 5'd0, off));  // bltz
        compare_bit("taken bltz", br_bus.taken, 1'b1);
        compare_word("target bltz", br_bus.target, br_target(pc, off));
        issue(pc, i_type(6'h01, 5'd10, 5'd17, off));  // bgezal
        compare_bit("taken bgezal", br_bus.taken, 1'b1);
        compare_reg("dest bgezal", ds_to_es_bus.dest, 5'd31);
        compare_bit("src2_is_8", ds_to_es_bus.src2_is_8, 1'b1);
        compare_bit("src1_is_pc", ds_to_es_bus.src1_is_pc, 1'b1);
        compare_bit("gr_we bgezal", ds_to_es_bus.gr_we, 1'b1);
        issue(pc, {6'h02, idx});  // j
        compare_bit("taken j", br_bus.taken, 1'b1);
        compare_word("target j", br_bus.target, {pc4[31:28], idx, 2'b00});
        issue(pc, r_type(5'd1, 5'd0, 5'd0, 5'd0, 6'h08));  // jr
        compare_bit("taken jr", br_bus.taken, 1'b1);
        compare_word("target jr", br_bus.target, d1);
        end_test("branches", start);
    endtask

    task automatic operand_hazards();
        int start;
        isa_pkg::word_t x;
        isa_pkg::word_t y;
        start = errors;
        x = $urandom();
        y = $urandom();
        @(negedge clk);  // let the previous instruction leave
        hazard_bus.es = '{1'b1, 5'd1, 1'b0, x};
        issue(32'h300, r_type(5'd1, 5'd2, 5'd3, 5'd0, 6'h21));
        repeat (3) begin
            compare_bit("ds_to_es_valid stalled", ds_to_es_valid, 1'b0);
            @(negedge clk);
            #2;
        end
        @(negedge clk);
        hazard_bus.es.fwd_valid = 1'b1;
        #2;
        wait_valid();
        compare_word("rs_value from es", ds_to_es_bus.rs_value, x);
        @(negedge clk);
        hazard_bus.ms = '{1'b1, 5'd1, 1'b1, y};
        issue(32'h304, r_type(5'd1, 5'd2, 5'd3, 5'd0, 6'h21));
        wait_valid();
        compare_word("rs_value es over ms", ds_to_es_bus.rs_value, x);
        @(negedge clk);
        hazard_bus.ms = '0;
        hazard_bus.es = '{1'b1, 5'd0, 1'b0, x};  // r0 never stalls
        issue(32'h308, r_type(5'd0, 5'd2, 5'd3, 5'd0, 6'h21));
        compare_bit("ds_to_es_valid r0", ds_to_es_valid, 1'b1);
        compare_word("rs_value r0", ds_to_es_bus.rs_value, 32'h0);
        @(negedge clk);
        hazard_bus = '0;
        end_test("hazards", start);
    endtask

    task automatic stall_and_flush();
        int start;
        pipe_pkg::ds_to_es_t held;
        start = errors;
        @(negedge clk);
        es_allowin = 1'b0;
        issue(32'h400, r_type(5'd1, 5'd2, 5'd3, 5'd0, 6'h21));
        wait_valid();
        held = ds_to_es_bus;
        @(negedge clk);
        fs_to_ds_valid = 1'b1;  // fetch keeps offering the next one
        fs_to_ds_bus   = '{32'h404, r_type(5'd2, 5'd1, 5'd4, 5'd0, 6'h23)};
        repeat (3) begin
            #2;
            compare_bit("ds_allowin held", ds_allowin, 1'b0);
            compare_bit("ds_to_es_valid held", ds_to_es_valid, 1'b1);
            compare_bit("ds_to_es_bus stable", ds_to_es_bus == held, 1'b1);
            @(negedge clk);
        end
        fs_to_ds_valid = 1'b0;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        #2;
        compare_bit("ds_to_es_valid after flush", ds_to_es_valid, 1'b0);
        compare_bit("ds_allowin after flush", ds_allowin, 1'b1);
        es_allowin = 1'b1;
        end_test("backpressure", start);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        tests  = 0;
        void'($urandom(32'ha7fc));
        reset          = 1'b1;
        flush          = 1'b0;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus   = '0;
        es_allowin     = 1'b1;
        ws_to_rf       = '0;
        hazard_bus     = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #2;
        alu_ops();
        imm_forms();
        branch_redirects();
        operand_hazards();
        stall_and_flush();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: hw/id_stage.sv
`include "cpu_macros.svh"

module id_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  fs_to_ds_valid,
    input  pipe_pkg::fetch_pkt_t  fs_to_ds_bus,
    output logic                  ds_allowin,
    input  logic                  es_allowin,
    output logic                  ds_to_es_valid,
    output pipe_pkg::ds_to_es_t   ds_to_es_bus,
    input  pipe_pkg::wb_pkt_t     ws_to_rf,
    input  pipe_pkg::hazard_bus_t hazard_bus,
    output pipe_pkg::br_pkt_t     br_bus
);

    logic                   ds_valid;
    pipe_pkg::fetch_pkt_t   ds_r;
    pipe_pkg::decode_ctrl_t ctrl;
    isa_pkg::word_t         rs_value;
    isa_pkg::word_t         rt_value;
    isa_pkg::word_t         br_target;
    logic                   ready;
    logic                   br_hit;

    assign ds_allowin     = !ds_valid || (ready && es_allowin);
    assign ds_to_es_valid = ds_valid && ready;

    always_ff @(posedge clk) begin
        if (reset || flush)
            ds_valid <= 1'b0;
        else if (ds_allowin)
            ds_valid <= fs_to_ds_valid;
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin)
            ds_r <= fs_to_ds_bus;
    end

    inst_decoder u_inst_decoder (
        .inst (ds_r.inst),
        .ctrl (ctrl)
    );

    operand_unit u_operand_unit (
        .clk      (clk),
        .rs       (ds_r.inst[25:21]),
        .rt       (ds_r.inst[20:16]),
        .uses_rs  (ctrl.uses_rs),
        .uses_rt  (ctrl.uses_rt),
        .wb       (ws_to_rf),
        .hazards  (hazard_bus),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .ready    (ready)
    );

    branch_unit u_branch_unit (
        .pc            (ds_r.pc),
        .imm           (ctrl.imm),
        .jidx_pc_field (ds_r.inst[`CPU_WORD_W-`CPU_OP_W-1:0]),
        .br_kind       (ctrl.br_kind),
        .jump_kind     (ctrl.jump_kind),
        .rs_value      (rs_value),
        .rt_value      (rt_value),
        .br_hit        (br_hit),
        .target        (br_target)
    );

    // redirect only once the operands are final
    assign br_bus.taken  = ds_valid && ready && br_hit;
    assign br_bus.target = br_target;

    always_comb begin
        ds_to_es_bus.alu_op       = ctrl.alu_op;
        ds_to_es_bus.load_op      = ctrl.load_op;
        ds_to_es_bus.store_op     = ctrl.store_op;
        ds_to_es_bus.ld_ext       = ctrl.ld_ext;
        ds_to_es_bus.st_size      = ctrl.st_size;
        ds_to_es_bus.src1_is_sa   = ctrl.src1_is_sa;
        ds_to_es_bus.src1_is_pc   = ctrl.src1_is_pc;
        ds_to_es_bus.src2_is_imm  = ctrl.src2_is_imm;
        ds_to_es_bus.src2_is_uimm = ctrl.src2_is_uimm;
        ds_to_es_bus.src2_is_8    = ctrl.src2_is_8;
        ds_to_es_bus.gr_we        = ctrl.gr_we;
        ds_to_es_bus.dest         = ctrl.dest;
        ds_to_es_bus.imm          = ctrl.imm;
        ds_to_es_bus.rs_value     = rs_value;
        ds_to_es_bus.rt_value     = rt_value;
        ds_to_es_bus.pc           = ds_r.pc;
    end

    // execute back-pressure must not let the offered packet drift
    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_allowin && !flush |=> $stable(ds_to_es_bus))
        else $error("ds_to_es_bus changed while stalled");

endmodule

// File: hw/branch_unit.sv
`include "cpu_macros.svh"

module branch_unit (
    input  isa_pkg::word_t                   pc,
    input  isa_pkg::imm_t                    imm,
    input  logic [`CPU_WORD_W-`CPU_OP_W-1:0] jidx_pc_field,
    input  pipe_pkg::br_kind_t               br_kind,
    input  pipe_pkg::jump_kind_t             jump_kind,
    input  isa_pkg::word_t                   rs_value,
    input  isa_pkg::word_t                   rt_value,
    output logic                             br_hit,
    output isa_pkg::word_t                   target
);

    isa_pkg::word_t pc_plus4;
    isa_pkg::word_t br_offset;
    logic eq;
    logic neg;
    logic pos;
    logic cond;

    assign pc_plus4  = pc + `CPU_WORD_W'(4);
    assign br_offset = {{(`CPU_WORD_W-18){imm[15]}}, imm, 2'b00};

    assign eq  = rs_value == rt_value;
    assign neg = $signed(rs_value) < 0;
    assign pos = $signed(rs_value) > 0;

    assign cond = (br_kind[0] && eq)  || (br_kind[1] && !eq)
               || (br_kind[2] && !neg) || (br_kind[3] && pos)
               || (br_kind[4] && !pos) || (br_kind[5] && neg);
    assign br_hit = cond || |jump_kind;  // jumps always redirect

    always_comb begin
        if (|br_kind)
            target = pc_plus4 + br_offset;
        else if (jump_kind[1])
            target = rs_value;
        else
            target = {pc_plus4[`CPU_WORD_W-1 -: 4], jidx_pc_field, 2'b00};  // region jump
    end

endmodule

// File: hw/operand_unit.sv
`include "cpu_macros.svh"

module operand_unit (
    input  logic                  clk,
    input  isa_pkg::reg_idx_t     rs,
    input  isa_pkg::reg_idx_t     rt,
    input  logic                  uses_rs,
    input  logic                  uses_rt,
    input  pipe_pkg::wb_pkt_t     wb,
    input  pipe_pkg::hazard_bus_t hazards,
    output isa_pkg::word_t        rs_value,
    output isa_pkg::word_t        rt_value,
    output logic                  ready
);

    isa_pkg::word_t rf_rs;
    isa_pkg::word_t rf_rt;
    logic [2:0] fwd_vld;  // {es, ms, ws}
    logic [2:0] rs_win;
    logic [2:0] rt_win;

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .rdata1 (rf_rs),
        .raddr2 (rt),
        .rdata2 (rf_rt),
        .wr     (wb)
    );

    // one-hot youngest matching stage, zero when the rf value stands
    function automatic logic [2:0] winner(input isa_pkg::reg_idx_t src, input logic used,
                                          input pipe_pkg::hazard_bus_t hz);
        logic chk;
        chk = used && src != `CPU_REG_W'(0);
        if (chk && hz.es.we && hz.es.dest == src) return 3'b100;
        if (chk && hz.ms.we && hz.ms.dest == src) return 3'b010;
        if (chk && hz.ws.we && hz.ws.dest == src) return 3'b001;
        return 3'b000;
    endfunction

    function automatic isa_pkg::word_t pick(input logic [2:0] win, input isa_pkg::word_t rf,
                                            input pipe_pkg::hazard_bus_t hz);
        case (win)
            3'b100:  return hz.es.fwd_data;
            3'b010:  return hz.ms.fwd_data;
            3'b001:  return hz.ws.fwd_data;
            default: return rf;
        endcase
    endfunction

    // source needs nothing pending from the youngest stage writing it
    function automatic logic src_final(input isa_pkg::reg_idx_t src, input logic used,
                                       input pipe_pkg::hazard_bus_t hz);
        if (!used || src == `CPU_REG_W'(0)) return 1'b1;
        if (hz.es.we && hz.es.dest == src) return hz.es.fwd_valid;
        if (hz.ms.we && hz.ms.dest == src) return hz.ms.fwd_valid;
        if (hz.ws.we && hz.ws.dest == src) return hz.ws.fwd_valid;
        return 1'b1;
    endfunction

    assign fwd_vld  = {hazards.es.fwd_valid, hazards.ms.fwd_valid, hazards.ws.fwd_valid};
    assign rs_win   = winner(rs, uses_rs, hazards);
    assign rt_win   = winner(rt, uses_rt, hazards);
    assign rs_value = pick(rs_win, rf_rs, hazards);
    assign rt_value = pick(rt_win, rf_rt, hazards);
    assign ready    = ((rs_win | rt_win) & ~fwd_vld) == 3'b000;  // no pending producer

    // a ready operand must come from a stage that holds its final result
    a_fwd_final: assert property (@(posedge clk)
        ready |-> src_final(rs, uses_rs, hazards) && src_final(rt, uses_rt, hazards))
        else $error("operand forwarded from a stage without final data");

endmodule

// File: hw/regfile.sv
`include "cpu_macros.svh"

module regfile (
    input  logic              clk,
    input  isa_pkg::reg_idx_t raddr1,
    output isa_pkg::word_t    rdata1,
    input  isa_pkg::reg_idx_t raddr2,
    output isa_pkg::word_t    rdata2,
    input  pipe_pkg::wb_pkt_t wr
);

    isa_pkg::word_t mem [`CPU_NUM_REGS];

    always_ff @(posedge clk) begin
        if (wr.we && wr.addr != '0) begin  // r0 stays zero
            mem[wr.addr] <= wr.data;
        end
    end

    // reads see the old value during a write cycle
    assign rdata1 = (raddr1 == '0) ? '0 : mem[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : mem[raddr2];

endmodule

// File: hw/inst_decoder.sv
`include "cpu_macros.svh"

module inst_decoder (
    input  isa_pkg::word_t         inst,
    output pipe_pkg::decode_ctrl_t ctrl
);

    isa_pkg::opcode_t  op;
    isa_pkg::func_t    func;
    isa_pkg::reg_idx_t rs;
    isa_pkg::reg_idx_t rt;
    isa_pkg::reg_idx_t rd;
    isa_pkg::reg_idx_t sa;
    logic r_arith;
    logic r_shift;
    logic regimm;
    logic i_sll, i_srl, i_sra, i_jr, i_jalr;
    logic i_addi, i_addiu, i_slti, i_sltiu, i_andi, i_ori, i_xori, i_lui;
    logic i_lb, i_lbu, i_lh, i_lhu, i_lw, i_sb, i_sh, i_sw;
    logic i_beq, i_bne, i_bgez, i_bgtz, i_blez, i_bltz, i_bgezal, i_bltzal, i_j, i_jal;
    logic link;

    // one pass from inst so the check below never sees a half-updated decode
    always_comb begin
        op      = inst[`CPU_WORD_W-1 -: `CPU_OP_W];
        func    = inst[`CPU_FUNC_W-1:0];
        rs      = inst[25:21];
        rt      = inst[20:16];
        rd      = inst[15:11];
        sa      = inst[10:6];
        r_arith = op == isa_pkg::OP_SPECIAL && sa == '0;  // three-register forms
        r_shift = op == isa_pkg::OP_SPECIAL && rs == '0;  // shift by sa
        regimm  = op == isa_pkg::OP_REGIMM;

        i_sll    = r_shift && func == isa_pkg::FN_SLL;
        i_srl    = r_shift && func == isa_pkg::FN_SRL;
        i_sra    = r_shift && func == isa_pkg::FN_SRA;
        i_jr     = r_arith && func == isa_pkg::FN_JR && rt == '0 && rd == '0;
        i_jalr   = r_arith && func == isa_pkg::FN_JALR && rt == '0;
        i_addi   = op == isa_pkg::OP_ADDI;
        i_addiu  = op == isa_pkg::OP_ADDIU;
        i_slti   = op == isa_pkg::OP_SLTI;
        i_sltiu  = op == isa_pkg::OP_SLTIU;
        i_andi   = op == isa_pkg::OP_ANDI;
        i_ori    = op == isa_pkg::OP_ORI;
        i_xori   = op == isa_pkg::OP_XORI;
        i_lui    = op == isa_pkg::OP_LUI && rs == '0;
        i_lb     = op == isa_pkg::OP_LB;
        i_lbu    = op == isa_pkg::OP_LBU;
        i_lh     = op == isa_pkg::OP_LH;
        i_lhu    = op == isa_pkg::OP_LHU;
        i_lw     = op == isa_pkg::OP_LW;
        i_sb     = op == isa_pkg::OP_SB;
        i_sh     = op == isa_pkg::OP_SH;
        i_sw     = op == isa_pkg::OP_SW;
        i_beq    = op == isa_pkg::OP_BEQ;
        i_bne    = op == isa_pkg::OP_BNE;
        i_bgtz   = op == isa_pkg::OP_BGTZ && rt == '0;
        i_blez   = op == isa_pkg::OP_BLEZ && rt == '0;
        i_bgez   = regimm && rt == isa_pkg::RT_BGEZ;
        i_bltz   = regimm && rt == isa_pkg::RT_BLTZ;
        i_bgezal = regimm && rt == isa_pkg::RT_BGEZAL;
        i_bltzal = regimm && rt == isa_pkg::RT_BLTZAL;
        i_j      = op == isa_pkg::OP_J;
        i_jal    = op == isa_pkg::OP_JAL;
        link     = i_jal || i_jalr || i_bgezal || i_bltzal;

        ctrl.load_op  = i_lb || i_lbu || i_lh || i_lhu || i_lw;
        ctrl.store_op = i_sb || i_sh || i_sw;
        ctrl.ld_ext   = {i_lb, i_lbu, i_lh, i_lhu, i_lw};
        ctrl.st_size  = {i_sb, i_sh, i_sw};
        ctrl.alu_op   = {
            i_lui,
            i_sra || (r_arith && func == isa_pkg::FN_SRAV),
            i_srl || (r_arith && func == isa_pkg::FN_SRLV),
            i_sll || (r_arith && func == isa_pkg::FN_SLLV),
            i_xori || (r_arith && func == isa_pkg::FN_XOR),
            i_ori || (r_arith && func == isa_pkg::FN_OR),
            r_arith && func == isa_pkg::FN_NOR,
            i_andi || (r_arith && func == isa_pkg::FN_AND),
            i_sltiu || (r_arith && func == isa_pkg::FN_SLTU),
            i_slti || (r_arith && func == isa_pkg::FN_SLT),
            r_arith && (func == isa_pkg::FN_SUB || func == isa_pkg::FN_SUBU),
            (r_arith && (func == isa_pkg::FN_ADD || func == isa_pkg::FN_ADDU))
                || i_addi || i_addiu || ctrl.load_op || ctrl.store_op || link
        };

        ctrl.src1_is_sa   = i_sll || i_srl || i_sra;
        ctrl.src1_is_pc   = link;
        ctrl.src2_is_imm  = i_addi || i_addiu || i_slti || i_sltiu || i_lui
                          || ctrl.load_op || ctrl.store_op;
        ctrl.src2_is_uimm = i_andi || i_ori || i_xori;
        ctrl.src2_is_8    = link;  // return address is pc + 8
        ctrl.gr_we        = !(ctrl.store_op || i_beq || i_bne || i_bgez || i_bgtz
                              || i_blez || i_bltz || i_j || i_jr);
        if (i_jal || i_bgezal || i_bltzal)
            ctrl.dest = 5'd31;
        else if ((ctrl.src2_is_imm && !ctrl.store_op) || ctrl.src2_is_uimm)
            ctrl.dest = rt;
        else
            ctrl.dest = rd;
        ctrl.imm       = inst[15:0];
        ctrl.uses_rs   = !(ctrl.src1_is_sa || i_lui || i_j || i_jal);
        ctrl.uses_rt   = (op == isa_pkg::OP_SPECIAL && |ctrl.alu_op) || i_beq || i_bne
                       || ctrl.store_op;
        ctrl.br_kind   = {i_bltz || i_bltzal, i_blez, i_bgtz, i_bgez || i_bgezal, i_bne, i_beq};
        ctrl.jump_kind = {i_jr || i_jalr, i_j || i_jal};

        if (!$isunknown(inst))
            assert ($onehot0(ctrl.alu_op))
            else $error("alu_op not one-hot for inst %h", inst);
    end

endmodule

// File: hw/pipe_pkg.sv
package pipe_pkg;

    typedef logic [5:0] br_kind_t;    // {bltz, blez, bgtz, bgez, bne, beq}
    typedef logic [1:0] jump_kind_t;  // {jr/jalr, j/jal}

    typedef struct packed {
        isa_pkg::word_t pc;
        isa_pkg::word_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic              we;
        isa_pkg::reg_idx_t addr;
        isa_pkg::word_t    data;
    } wb_pkt_t;

    typedef struct packed {
        logic              we;
        isa_pkg::reg_idx_t dest;
        logic              fwd_valid;  // fwd_data is the final result
        isa_pkg::word_t    fwd_data;
    } hazard_src_t;

    typedef struct packed {
        hazard_src_t es;
        hazard_src_t ms;
        hazard_src_t ws;
    } hazard_bus_t;

    typedef struct packed {
        isa_pkg::alu_op_t  alu_op;
        logic              load_op;
        logic              store_op;
        isa_pkg::ld_ext_t  ld_ext;
        isa_pkg::st_size_t st_size;
        logic              src1_is_sa;
        logic              src1_is_pc;
        logic              src2_is_imm;
        logic              src2_is_uimm;
        logic              src2_is_8;
        logic              gr_we;
        isa_pkg::reg_idx_t dest;
        isa_pkg::imm_t     imm;
        logic              uses_rs;
        logic              uses_rt;
        br_kind_t          br_kind;
        jump_kind_t        jump_kind;
    } decode_ctrl_t;

    typedef struct packed {
        isa_pkg::alu_op_t  alu_op;
        logic              load_op;
        logic              store_op;
        isa_pkg::ld_ext_t  ld_ext;
        isa_pkg::st_size_t st_size;
        logic              src1_is_sa;
        logic              src1_is_pc;
        logic              src2_is_imm;
        logic              src2_is_uimm;
        logic              src2_is_8;
        logic              gr_we;
        isa_pkg::reg_idx_t dest;
        isa_pkg::imm_t     imm;
        isa_pkg::word_t    rs_value;
        isa_pkg::word_t    rt_value;
        isa_pkg::word_t    pc;
    } ds_to_es_t;

    typedef struct packed {
        logic           taken;
        isa_pkg::word_t target;
    } br_pkt_t;

endpackage

// File: hw/isa_pkg.sv
`include "cpu_macros.svh"

package isa_pkg;

    typedef logic [`CPU_WORD_W-1:0]  word_t;
    typedef logic [`CPU_REG_W-1:0]   reg_idx_t;
    typedef logic [15:0]             imm_t;
    typedef logic [`CPU_OP_W-1:0]    opcode_t;
    typedef logic [`CPU_FUNC_W-1:0]  func_t;
    // bit 0 add, then sub slt sltu and nor or xor sll srl sra, bit 11 lui
    typedef logic [`CPU_ALU_OPS-1:0] alu_op_t;
    typedef logic [4:0]              ld_ext_t;   // {lb, lbu, lh, lhu, lw}
    typedef logic [2:0]              st_size_t;  // {sb, sh, sw}

    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_REGIMM  = 6'h01;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_BLEZ    = 6'h06;
    localparam opcode_t OP_BGTZ    = 6'h07;
    localparam opcode_t OP_ADDI    = 6'h08;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_SLTIU   = 6'h0b;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LB      = 6'h20;
    localparam opcode_t OP_LH      = 6'h21;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_LBU     = 6'h24;
    localparam opcode_t OP_LHU     = 6'h25;
    localparam opcode_t OP_SB      = 6'h28;
    localparam opcode_t OP_SH      = 6'h29;
    localparam opcode_t OP_SW      = 6'h2b;

    localparam func_t FN_SLL  = 6'h00;
    localparam func_t FN_SRL  = 6'h02;
    localparam func_t FN_SRA  = 6'h03;
    localparam func_t FN_SLLV = 6'h04;
    localparam func_t FN_SRLV = 6'h06;
    localparam func_t FN_SRAV = 6'h07;
    localparam func_t FN_JR   = 6'h08;
    localparam func_t FN_JALR = 6'h09;
    localparam func_t FN_ADD  = 6'h20;
    localparam func_t FN_ADDU = 6'h21;
    localparam func_t FN_SUB  = 6'h22;
    localparam func_t FN_SUBU = 6'h23;
    localparam func_t FN_AND  = 6'h24;
    localparam func_t FN_OR   = 6'h25;
    localparam func_t FN_XOR  = 6'h26;
    localparam func_t FN_NOR  = 6'h27;
    localparam func_t FN_SLT  = 6'h2a;
    localparam func_t FN_SLTU = 6'h2b;

    // regimm branches select on the rt field
    localparam reg_idx_t RT_BLTZ   = 5'h00;
    localparam reg_idx_t RT_BGEZ   = 5'h01;
    localparam reg_idx_t RT_BLTZAL = 5'h10;
    localparam reg_idx_t RT_BGEZAL = 5'h11;

endpackage

// File: hw/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and address width
`define CPU_WORD_W   32
`define CPU_REG_W    5
`define CPU_NUM_REGS 32
`define CPU_ALU_OPS  12

// instruction field widths
`define CPU_OP_W     6
`define CPU_FUNC_W   6

`endif
